// File: src/tsense_pkg.sv
`default_nettype none

package tsense_pkg;

  // number of sensing channels on the bus
  localparam int unsigned NumChannels = 4;

  typedef logic [7:0]  addr_t;      // register byte address
  typedef logic [31:0] data_t;      // bus data word
  typedef logic [23:0] count_t;     // channel edge count
  typedef logic [3:0]  conv_sel_t;  // window is 16 << sel cycles
  typedef logic [1:0]  osc_sel_t;   // monitor select

  ////////////////////
  // register map
  ////////////////////
  localparam addr_t RegResetN   = 8'h04;
  localparam addr_t RegConvSel  = 8'h08;
  localparam addr_t RegEn       = 8'h0C;
  localparam addr_t RegDoutBase = 8'h10; // channel k at +8k
  localparam addr_t RegDoneBase = 8'h14; // channel k at +8k
  localparam addr_t RegOscSel   = 8'h30;

  // per channel conversion sequence
  typedef enum logic [1:0] {
    IDLE,
    COUNT,
    DONE
  } chan_state_e;

endpackage

`default_nettype wire

// File: src/tsense_bus_decode.sv
`default_nettype none

module tsense_bus_decode import tsense_pkg::*; (
  // request channel from the master
  input  logic  a_valid_i,
  input  logic  a_write_i,
  input  addr_t a_addr_i,
  input  data_t a_wdata_i,
  output logic  a_ready_o,

  // from the response block
  input  logic  outstanding_i,

  // strobes, valid only in the accepting cycle
  output logic  wr_req_o,
  output logic  rd_req_o,
  output logic  req_err_o,
  output addr_t addr_o,
  output data_t wdata_o
);

  logic accept;
  logic misaligned;

  // one transaction in flight, so ready is just "nothing pending"
  assign a_ready_o = ~outstanding_i;
  assign accept    = a_valid_i & ~outstanding_i;

  // only writes care about the low address bits
  assign misaligned = |a_addr_i[1:0];

  ////////////////////
  // strobes
  ////////////////////
  assign wr_req_o  = accept & a_write_i & ~misaligned;
  assign rd_req_o  = accept & ~a_write_i;
  assign req_err_o = accept & a_write_i & misaligned; // no register touched

  // registers are word wide
  assign addr_o  = {a_addr_i[7:2], 2'b00};
  assign wdata_o = a_wdata_i;

endmodule

`default_nettype wire

// File: src/tsense_ctrl_regs.sv
`default_nettype none

module tsense_ctrl_regs import tsense_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // accepted write from the decoder
  input  logic      wr_req_i,
  input  addr_t     addr_i,
  input  data_t     wdata_i,

  // control fields fanned out to the channels
  output logic      reset_n_o,
  output conv_sel_t conv_sel_o,
  output logic      en_o,
  output osc_sel_t  osc_sel_o
);

  logic      reset_n_q;
  conv_sel_t conv_sel_q;
  logic      en_q;
  osc_sel_t  osc_sel_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reset_n_q  <= 1'b1; // counters released out of reset
      conv_sel_q <= '0;
      en_q       <= 1'b0;
      osc_sel_q  <= '0;
    end else if (wr_req_i) begin
      // read-only and unmapped offsets fall through
      case (addr_i)
        RegResetN:  reset_n_q  <= wdata_i[0];
        RegConvSel: conv_sel_q <= wdata_i[3:0];
        RegEn:      en_q       <= wdata_i[0];
        RegOscSel:  osc_sel_q  <= wdata_i[1:0];
        default:    ;
      endcase
    end
  end

  assign reset_n_o  = reset_n_q;
  assign conv_sel_o = conv_sel_q;
  assign en_o       = en_q;
  assign osc_sel_o  = osc_sel_q;

endmodule

`default_nettype wire

// File: src/tsense_channel.sv
`default_nettype none

module tsense_channel import tsense_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  input  logic      osc_i,      // async to clk_i
  input  logic      reset_n_i,
  input  conv_sel_t conv_sel_i,
  input  logic      en_i,

  output logic      osc_sync_o,
  output count_t    dout_o,
  output logic      done_o
);

  logic        osc_meta_q;
  logic        osc_sync_q;
  logic        osc_prev_q;
  logic        osc_rise;

  chan_state_e state_q;
  count_t      timer_q;
  count_t      edge_cnt_q;
  count_t      dout_q;
  logic        done_q;
  count_t      win_last;

  ////////////////////
  // input sync
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      osc_meta_q <= 1'b0;
      osc_sync_q <= 1'b0;
      osc_prev_q <= 1'b0;
    end else begin
      osc_meta_q <= osc_i;
      osc_sync_q <= osc_meta_q;
      osc_prev_q <= osc_sync_q; // edge detect stage
    end
  end

  assign osc_rise = osc_sync_q & ~osc_prev_q;

  // last cycle of the window, 16 << sel long
  assign win_last = (count_t'(16) << conv_sel_i) - count_t'(1);

  ////////////////////
  // conversion FSM
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      timer_q    <= '0;
      edge_cnt_q <= '0;
      dout_q     <= '0;
      done_q     <= 1'b0;
    end else if (!reset_n_i) begin
      // software counter reset wipes the result too
      state_q    <= IDLE;
      timer_q    <= '0;
      edge_cnt_q <= '0;
      dout_q     <= '0;
      done_q     <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          timer_q    <= '0;
          edge_cnt_q <= '0;
          if (en_i) begin
            state_q <= COUNT;
          end
        end
        COUNT: begin
          if (!en_i) begin
            state_q <= IDLE; // aborted, result untouched
          end else if (timer_q == win_last) begin
            state_q <= DONE;
            dout_q  <= edge_cnt_q + count_t'(osc_rise);
            done_q  <= 1'b1;
          end else begin
            timer_q    <= timer_q + count_t'(1);
            edge_cnt_q <= edge_cnt_q + count_t'(osc_rise);
          end
        end
        DONE: begin
          // hold result until software drops en
          if (!en_i) begin
            state_q <= IDLE;
            done_q  <= 1'b0;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign osc_sync_o = osc_sync_q;
  assign dout_o     = dout_q;
  assign done_o     = done_q;

endmodule

`default_nettype wire

// File: src/tsense_rsp.sv
`default_nettype none

module tsense_rsp import tsense_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // strobes from the decoder
  input  logic                   rd_req_i,
  input  logic                   wr_req_i,
  input  logic                   req_err_i,
  input  addr_t                  addr_i,

  // register state for read-back
  input  logic                   reset_n_i,
  input  conv_sel_t              conv_sel_i,
  input  logic                   en_i,
  input  osc_sel_t               osc_sel_i,
  input  count_t                 dout_i [NumChannels],
  input  logic [NumChannels-1:0] done_i,

  // response channel
  input  logic                   d_ready_i,
  output logic                   outstanding_o,
  output logic                   d_valid_o,
  output data_t                  d_rdata_o,
  output logic                   d_error_o
);

  logic  accept;
  logic  d_ack;
  logic  outstanding_q;
  data_t rdata_q;
  logic  error_q;
  data_t rd_mux;

  assign accept = rd_req_i | wr_req_i | req_err_i;
  assign d_ack  = outstanding_q & d_ready_i;

  // read-back mux, unmapped reads give zero
  always_comb begin
    rd_mux = '0;
    case (addr_i)
      RegResetN:  rd_mux = data_t'(reset_n_i);
      RegConvSel: rd_mux = data_t'(conv_sel_i);
      RegEn:      rd_mux = data_t'(en_i);
      RegOscSel:  rd_mux = data_t'(osc_sel_i);
      default: begin
        for (int k = 0; k < NumChannels; k++) begin
          if (addr_i == addr_t'(RegDoutBase + 8 * k)) begin
            rd_mux = data_t'(dout_i[k]);
          end
          if (addr_i == addr_t'(RegDoneBase + 8 * k)) begin
            rd_mux = data_t'(done_i[k]);
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
      rdata_q       <= '0;
      error_q       <= 1'b0;
    end else if (accept) begin
      outstanding_q <= 1'b1;
      rdata_q       <= rd_req_i ? rd_mux : '0; // writes answer with 0
      error_q       <= req_err_i;
    end else if (d_ack) begin
      outstanding_q <= 1'b0;
      error_q       <= 1'b0; // keep error low while idle
    end
  end

  assign outstanding_o = outstanding_q;
  assign d_valid_o     = outstanding_q;
  assign d_rdata_o     = rdata_q;
  assign d_error_o     = error_q;

endmodule

`default_nettype wire

// File: src/tsense_top.sv
`default_nettype none

module tsense_top import tsense_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // request channel
  input  logic                   a_valid_i,
  input  logic                   a_write_i,
  input  addr_t                  a_addr_i,
  input  data_t                  a_wdata_i,
  output logic                   a_ready_o,

  // response channel
  output logic                   d_valid_o,
  output data_t                  d_rdata_o,
  output logic                   d_error_o,
  input  logic                   d_ready_i,

  input  logic [NumChannels-1:0] osc_i,
  output logic                   mon_osc_o
);

  logic                   outstanding;
  logic                   wr_req;
  logic                   rd_req;
  logic                   req_err;
  addr_t                  addr;
  data_t                  wdata;

  logic                   reset_n;
  conv_sel_t              conv_sel;
  logic                   en;
  osc_sel_t               osc_sel;

  logic [NumChannels-1:0] osc_sync;
  count_t                 dout [NumChannels];
  logic [NumChannels-1:0] done;

  ////////////////////
  // bus side
  ////////////////////
  tsense_bus_decode u_decode (
    .a_valid_i     (a_valid_i),
    .a_write_i     (a_write_i),
    .a_addr_i      (a_addr_i),
    .a_wdata_i     (a_wdata_i),
    .a_ready_o     (a_ready_o),
    .outstanding_i (outstanding),
    .wr_req_o      (wr_req),
    .rd_req_o      (rd_req),
    .req_err_o     (req_err),
    .addr_o        (addr),
    .wdata_o       (wdata)
  );

  tsense_ctrl_regs u_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_req_i   (wr_req),
    .addr_i     (addr),
    .wdata_i    (wdata),
    .reset_n_o  (reset_n),
    .conv_sel_o (conv_sel),
    .en_o       (en),
    .osc_sel_o  (osc_sel)
  );

  tsense_rsp u_rsp (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req),
    .wr_req_i      (wr_req),
    .req_err_i     (req_err),
    .addr_i        (addr),
    .reset_n_i     (reset_n),
    .conv_sel_i    (conv_sel),
    .en_i          (en),
    .osc_sel_i     (osc_sel),
    .dout_i        (dout),
    .done_i        (done),
    .d_ready_i     (d_ready_i),
    .outstanding_o (outstanding),
    .d_valid_o     (d_valid_o),
    .d_rdata_o     (d_rdata_o),
    .d_error_o     (d_error_o)
  );

  ////////////////////
  // sensing channels
  ////////////////////
  tsense_channel u_chan0 (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .osc_i      (osc_i[0]),
    .reset_n_i  (reset_n),
    .conv_sel_i (conv_sel),
    .en_i       (en),
    .osc_sync_o (osc_sync[0]),
    .dout_o     (dout[0]),
    .done_o     (done[0])
  );

  tsense_channel u_chan1 (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .osc_i      (osc_i[1]),
    .reset_n_i  (reset_n),
    .conv_sel_i (conv_sel),
    .en_i       (en),
    .osc_sync_o (osc_sync[1]),
    .dout_o     (dout[1]),
    .done_o     (done[1])
  );

  tsense_channel u_chan2 (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .osc_i      (osc_i[2]),
    .reset_n_i  (reset_n),
    .conv_sel_i (conv_sel),
    .en_i       (en),
    .osc_sync_o (osc_sync[2]),
    .dout_o     (dout[2]),
    .done_o     (done[2])
  );

  tsense_channel u_chan3 (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .osc_i      (osc_i[3]),
    .reset_n_i  (reset_n),
    .conv_sel_i (conv_sel),
    .en_i       (en),
    .osc_sync_o (osc_sync[3]),
    .dout_o     (dout[3]),
    .done_o     (done[3])
  );

  // monitor picks one synchronized oscillator
  always_comb begin
    case (osc_sel)
      2'd0: mon_osc_o = osc_sync[0];
      2'd1: mon_osc_o = osc_sync[1];
      2'd2: mon_osc_o = osc_sync[2];
      2'd3: mon_osc_o = osc_sync[3];
      default: mon_osc_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: testbench/tsense_asserts.sv
`default_nettype none

module tsense_asserts import tsense_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  a_valid_i,
  input logic  a_ready_o,
  input logic  d_valid_o,
  input logic  d_ready_i,
  input logic  d_error_o,
  input data_t d_rdata_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // an accepted request closes the request channel behind its response
  ready_valid_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (a_valid_i && a_ready_o) |=> (d_valid_o && !a_ready_o))
    else $error("a_ready_o still high while a response is pending");

  // response held under back-pressure
  rsp_held_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (d_valid_o && !d_ready_i) |=> (d_valid_o && $stable(d_rdata_o) && $stable(d_error_o)))
    else $error("response changed before it was taken");

  error_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !d_valid_o |-> !d_error_o)
    else $error("d_error_o high without d_valid_o");

endmodule

bind tsense_top tsense_asserts u_asserts (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .a_valid_i (a_valid_i),
  .a_ready_o (a_ready_o),
  .d_valid_o (d_valid_o),
  .d_ready_i (d_ready_i),
  .d_error_o (d_error_o),
  .d_rdata_o (d_rdata_o)
);

`default_nettype wire

// File: testbench/tsense_tb.sv
`default_nettype none

module tsense_tb import tsense_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ReqTimeout = 50;  // cycles
  localparam int RspTimeout = 50;
  localparam int PollLimit  = 100; // reads of a done flag

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       a_valid_i;
  logic       a_write_i;
  addr_t      a_addr_i;
  data_t      a_wdata_i;
  logic       a_ready_o;
  logic       d_valid_o;
  data_t      d_rdata_o;
  logic       d_error_o;
  logic       d_ready_i;
  logic [3:0] osc_i;
  logic       mon_osc_o;

  logic [51:0] vectors [64]; // op, addr, data, err
  int          half_cyc [4];
  logic [31:0] lfsr_q = 32'hc0f2fb10;

  always #10 clk_i = ~clk_i;

  tsense_top dut0 (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .a_valid_i (a_valid_i),
    .a_write_i (a_write_i),
    .a_addr_i  (a_addr_i),
    .a_wdata_i (a_wdata_i),
    .a_ready_o (a_ready_o),
    .d_valid_o (d_valid_o),
    .d_rdata_o (d_rdata_o),
    .d_error_o (d_error_o),
    .d_ready_i (d_ready_i),
    .osc_i     (osc_i),
    .mon_osc_o (mon_osc_o)
  );

  ////////////////////
  // helpers
  ////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_eq(input string name, input data_t got, input data_t exp);
    assert (got === exp) else begin
      abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // galois form with taps for x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int nbits, output int value);
    value = 0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value  = (value << 1) | int'(lfsr_q[0]);
    end
  endtask

  // free running with the phase kept off the clock edges
  task automatic run_osc(input int k);
    #(3 + 4 * k);
    forever begin
      #(half_cyc[k] * 20);
      osc_i[k] = ~osc_i[k];
    end
  endtask

  ////////////////////
  // bus access
  ////////////////////
  task automatic send_req(input logic wr, input addr_t addr, input data_t wdata);
    int n;
    @(negedge clk_i);
    a_valid_i = 1'b1;
    a_write_i = wr;
    a_addr_i  = addr;
    a_wdata_i = wdata;
    n = 0;
    while (!a_ready_o) begin
      if (n > ReqTimeout) abort_run($sformatf("request to 0x%h never accepted", addr));
      @(negedge clk_i);
      n++;
    end
    @(negedge clk_i); // accepted on the edge just passed
    a_valid_i = 1'b0;
  endtask

  task automatic collect_rsp(output data_t rdata, output logic err);
    int hold;
    int n;
    rand_bits(2, hold);
    repeat (hold) @(negedge clk_i); // back-pressure
    d_ready_i = 1'b1;
    n = 0;
    while (!d_valid_o) begin
      if (n > RspTimeout) abort_run("no response arrived on the d channel");
      @(negedge clk_i);
      n++;
    end
    rdata = d_rdata_o;
    err   = d_error_o;
    @(negedge clk_i);
    d_ready_i = 1'b0;
  endtask

  task automatic bus_access(input logic wr, input addr_t addr, input data_t wdata,
                            output data_t rdata, output logic err);
    send_req(wr, addr, wdata);
    collect_rsp(rdata, err);
  endtask

  task automatic run_vector(input logic [51:0] v);
    logic [7:0] op;
    addr_t      addr;
    data_t      data;
    data_t      rdata;
    logic       err;
    int         polls;
    op   = v[51:44];
    addr = v[43:36];
    data = v[35:4];
    case (op)
      8'h57: begin // W
        bus_access(1'b1, addr, data, rdata, err);
        check_eq("d_rdata_o", rdata, '0);
      end
      8'h52: begin // R
        bus_access(1'b0, addr, '0, rdata, err);
        check_eq($sformatf("d_rdata_o at 0x%h", addr), rdata, data);
      end
      8'h50: begin // P
        polls = 0;
        bus_access(1'b0, addr, '0, rdata, err);
        while (rdata !== data) begin
          polls++;
          if (polls > PollLimit) abort_run($sformatf("done flag at 0x%h never set", addr));
          bus_access(1'b0, addr, '0, rdata, err);
        end
      end
      default: abort_run($sformatf("unknown opcode 0x%h in vector file", op));
    endcase
    check_eq("d_error_o", data_t'(err), data_t'(v[3:0]));
  endtask

  // measures one period of the selected oscillator with the response held back
  task automatic check_monitor(input int sel);
    int    n;
    int    period;
    int    low_cyc;
    logic  prev;
    data_t rdata;
    logic  err;
    low_cyc = 0;
    send_req(1'b1, RegOscSel, data_t'(sel));
    n = 0;
    prev = mon_osc_o;
    @(negedge clk_i);
    while (!(mon_osc_o && !prev)) begin
      if (n > 4 * half_cyc[sel] + 8) abort_run("monitor output never rose");
      prev = mon_osc_o;
      @(negedge clk_i);
      n++;
    end
    period = 0;
    prev = mon_osc_o;
    @(negedge clk_i);
    period++;
    while (!(mon_osc_o && !prev)) begin
      if (!mon_osc_o) low_cyc++;
      if (period > 4 * half_cyc[sel] + 8) abort_run("monitor output rose only once");
      prev = mon_osc_o;
      @(negedge clk_i);
      period++;
    end
    check_eq("mon_osc_o low cycles", data_t'(low_cyc), data_t'(half_cyc[sel]));
    check_eq("mon_osc_o period", data_t'(period), data_t'(2 * half_cyc[sel]));
    collect_rsp(rdata, err);
    check_eq("d_error_o", data_t'(err), '0);
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    rst_ni    = 1'b0;
    a_valid_i = 1'b0;
    a_write_i = 1'b0;
    a_addr_i  = '0;
    a_wdata_i = '0;
    d_ready_i = 1'b0;
    osc_i     = '0;

    $readmemh("testbench/tsense_vectors.txt", vectors);
    assert (vectors[0][51:44] === 8'h48) else abort_run("vector file lacks the half-period line");
    for (int k = 0; k < 4; k++) begin
      half_cyc[k] = int'(vectors[0][4 + 8 * k +: 8]);
    end
    fork
      run_osc(0);
      run_osc(1);
      run_osc(2);
      run_osc(3);
    join_none

    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_eq("a_ready_o", data_t'(a_ready_o), 32'h1);
    check_eq("d_valid_o", data_t'(d_valid_o), '0);
    check_eq("d_error_o", data_t'(d_error_o), '0);

    for (int i = 1; i < 64; i++) begin
      if (vectors[i][51:44] === 8'h45) break; // end marker
      run_vector(vectors[i]);
    end

    for (int s = 0; s < 4; s++) begin
      check_monitor(s);
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tsense_vectors.txt
// op_addr_data_err, op in ascii: 48 half-periods, 57 write, 52 read, 50 poll, 45 end
// half-period line packs ch3..ch0 in data bytes, read data is the expected value
48_00_10080402_0
52_04_00000001_0 // reset values
52_08_00000000_0
52_0C_00000000_0
52_30_00000000_0
52_14_00000000_0
52_1C_00000000_0
52_24_00000000_0
52_2C_00000000_0
57_08_00000005_0 // write and read back
52_08_00000005_0
57_30_00000003_0
52_30_00000003_0
57_30_00000000_0
57_10_12345678_0 // result regs are read only
52_10_00000000_0
52_40_00000000_0 // unmapped
52_09_00000005_0 // low addr bits ignored on reads
57_0A_0000000F_1 // misaligned write
52_08_00000005_0
57_08_00000002_0 // window 64 cycles
57_0C_00000001_0
50_14_00000001_0
50_1C_00000001_0
50_24_00000001_0
50_2C_00000001_0
52_10_00000010_0
52_18_00000008_0
52_20_00000004_0
52_28_00000002_0
57_0C_00000000_0 // en off clears done
52_14_00000000_0
52_2C_00000000_0
52_10_00000010_0
52_28_00000002_0
57_04_00000000_0 // counter reset
52_10_00000000_0
52_28_00000000_0
57_04_00000001_0
45_00_00000000_0

// File: filelist.f
src/tsense_pkg.sv
src/tsense_bus_decode.sv
src/tsense_ctrl_regs.sv
src/tsense_channel.sv
src/tsense_rsp.sv
src/tsense_top.sv
testbench/tsense_asserts.sv
testbench/tsense_tb.sv
